//--- src/life_pkg.sv
/*
 * Shared types for the 8x8 Life engine. The grid size is fixed here and
 * nowhere else. Cell (r, c) sits at flat bit r*8+c, serial order is MSB first.
 */

package life_pkg;

    // Grid geometry
    localparam int GRID_ROWS  = 8;
    localparam int GRID_COLS  = 8;
    localparam int GRID_CELLS = GRID_ROWS * GRID_COLS;  // 64 cells

    // Live-cell count needs to reach GRID_CELLS itself
    localparam int POP_W = $clog2(GRID_CELLS + 1);      // 7 bits

    // Width of the generation count on the host pins
    localparam int GEN_W = 8;

    // One grid word, seen either as a flat vector or as rows of cells
    typedef union packed {
        logic [GRID_CELLS-1:0]               flat;  // Serial and memory view
        logic [GRID_ROWS-1:0][GRID_COLS-1:0] rows;  // rows[r][c] for the rule logic
    } grid_t;

    // Monitor output, registered once per cycle
    typedef struct packed {
        logic [POP_W-1:0] population;  // Live cells, 0 to 64
        logic             stable;      // Next generation equals current
    } status_t;

endpackage

//--- src/system_memory.sv
/*
 * Current-generation store with serial load and serial unload.
 * Priority is run, then load, then output. Loading fills the output register
 * too, so a readback straight after a load returns the loaded grid.
 */
`timescale 1ns/100ps

module system_memory (
    input  logic            CLK,          // System clock
    input  logic            RESET,        // Async reset, active high
    input  life_pkg::grid_t grid_in,      // Next generation from the calculator
    input  logic            serial_in,    // Load bit, MSB first
    input  logic            load_mode,    // Shift serial_in into both registers
    input  logic            run_mode,     // Take grid_in, one generation per cycle
    input  logic            output_mode,  // Drain the output register
    output life_pkg::grid_t grid_out,     // Current generation in parallel
    output logic            serial_out    // Registered top bit of the output register
);

    localparam int MSB = life_pkg::GRID_CELLS - 1;

    logic [MSB:0] in_sr;   // Current generation
    logic [MSB:0] out_sr;  // Copy that gets shifted out

    // Input register only changes on run or load
    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            in_sr <= '0;
        end else if (run_mode) begin
            in_sr <= grid_in.flat;                   // New generation
        end else if (load_mode) begin
            in_sr <= {in_sr[MSB-1:0], serial_in};    // Shift up, new bit at bottom
        end
    end

    // Output register follows the input register on run and load,
    // and drains towards serial_out in output mode
    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            out_sr     <= '0;
            serial_out <= 1'b0;
        end else if (run_mode) begin
            out_sr <= grid_in.flat;                  // Keep in step with in_sr
        end else if (load_mode) begin
            out_sr <= {out_sr[MSB-1:0], serial_in};  // Same shift as in_sr
        end else if (output_mode) begin
            serial_out <= out_sr[MSB];               // Top bit leaves first
            out_sr     <= {out_sr[MSB-1:0], 1'b0};   // Zero fill from below
        end
    end

    // serial_out holds its last value outside output mode

    assign grid_out.flat = in_sr;  // Parallel view of the current generation

endmodule

//--- src/grid_calculator.sv
/*
 * Purely combinational B3/S23 next-generation logic for the whole grid.
 * WRAP=1 gives a torus, WRAP=0 treats every cell beyond the edge as dead.
 * One generation per clock at the top level, so this path is the long one.
 */
`timescale 1ns/100ps

module grid_calculator #(
    parameter int WRAP = 1  // 1 toroidal, 0 dead edges
) (
    input  life_pkg::grid_t grid,      // Current generation
    output life_pkg::grid_t next_grid  // Generation after one step
);

    localparam int ROWS = life_pkg::GRID_ROWS;
    localparam int COLS = life_pkg::GRID_COLS;

    // Offsets of the eight neighbours, row then column
    localparam int NBR_DR [8] = '{-1, -1, -1,  0, 0,  1, 1, 1};
    localparam int NBR_DC [8] = '{-1,  0,  1, -1, 1, -1, 0, 1};

    // B3/S23
    function automatic logic life_rule(input logic alive, input logic [3:0] count);
        logic born;
        logic keep;
        born = (count == 4'd3);              // Birth, or survival with three
        keep = alive && (count == 4'd2);     // Survival with two
        return born || keep;
    endfunction

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col

            logic [7:0] nbr;    // The eight neighbour cells of (r, c)
            logic [3:0] count;  // Live neighbours, 0 to 8

            for (genvar k = 0; k < 8; k++) begin : g_nbr
                // Raw neighbour position, may fall off the grid
                localparam int RR = r + NBR_DR[k];
                localparam int CC = c + NBR_DC[k];

                // Same position folded back onto the torus
                localparam int RW = (RR + ROWS) % ROWS;
                localparam int CW = (CC + COLS) % COLS;

                localparam bit INSIDE = (RR >= 0) && (RR < ROWS) &&
                                        (CC >= 0) && (CC < COLS);

                if (WRAP != 0) begin : g_wrap
                    assign nbr[k] = grid.rows[RW][CW];   // Opposite edge wraps in
                end else if (INSIDE) begin : g_inside
                    assign nbr[k] = grid.rows[RR][CC];
                end else begin : g_dead
                    assign nbr[k] = 1'b0;                // Beyond the edge is dead
                end
            end

            // Small popcount, synthesises to an adder tree
            assign count = 4'($countones(nbr));

            assign next_grid.rows[r][c] = life_rule(grid.rows[r][c], count);
        end
    end

endmodule

//--- src/run_sequencer.sv
/*
 * Runs gen_count generations after a start pulse, one per cycle.
 * start is ignored while busy or while a serial transfer mode is set.
 * done pulses once, the cycle after the last run cycle (or after start if N=0).
 */
`timescale 1ns/100ps

module run_sequencer (
    input  logic                      CLK,          // System clock
    input  logic                      RESET,        // Async reset, active high
    input  logic                      start,        // One-cycle request
    input  logic                      load_mode,    // Serial load in progress
    input  logic                      output_mode,  // Serial unload in progress
    input  logic [life_pkg::GEN_W-1:0] gen_count,   // Generations, sampled with start
    output logic                      run_mode,     // Memory takes next_grid
    output logic                      busy,         // Run accepted and not yet finished
    output logic                      done          // End of run pulse
);

    logic [life_pkg::GEN_W-1:0] gens_left;  // Run cycles still to go
    logic                       accept;     // Start taken this cycle
    logic                       last_gen;   // Final run cycle

    // Only an idle engine with the serial pins quiet takes a start
    assign accept = start && !busy && !load_mode && !output_mode;

    assign last_gen = run_mode && (gens_left == life_pkg::GEN_W'(1));

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            run_mode  <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            gens_left <= '0;
        end else begin
            done <= 1'b0;  // Pulse by default low

            if (accept) begin
                busy      <= 1'b1;
                gens_left <= gen_count;
                run_mode  <= (gen_count != '0);  // First run cycle follows start
                done      <= (gen_count == '0);  // Nothing to run
            end else if (run_mode) begin
                gens_left <= gens_left - 1'b1;
                if (last_gen) begin
                    run_mode <= 1'b0;
                    done     <= 1'b1;            // Cycle after the last run
                end
            end else if (done) begin
                busy <= 1'b0;                    // Released after the done cycle
            end
        end
    end

    // busy covers the run cycles and the done cycle, so a new
    // start is taken one cycle after done at the earliest

endmodule

//--- src/population_monitor.sv
/*
 * Registered live-cell count and stable flag, one cycle behind the grid.
 * stable compares the current grid with the calculator output, so an
 * empty grid or a still life reports stable and an oscillator never does.
 */
`timescale 1ns/100ps

module population_monitor (
    input  logic              CLK,        // System clock
    input  logic              RESET,      // Async reset, active high
    input  life_pkg::grid_t   cur_grid,   // Current generation
    input  life_pkg::grid_t   next_grid,  // Calculator output for cur_grid
    output life_pkg::status_t status      // Population and stable flag
);

    localparam int CELLS = life_pkg::GRID_CELLS;
    localparam int POP_W = life_pkg::POP_W;

    life_pkg::status_t status_d;  // Unregistered status

    // Count of set bits over the flat view
    function automatic logic [POP_W-1:0] popcount(input logic [CELLS-1:0] cells);
        logic [POP_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < CELLS; i++) begin
            sum = sum + POP_W'(cells[i]);  // Adds 0 or 1
        end
        return sum;
    endfunction

    always_comb begin
        status_d.population = popcount(cur_grid.flat);
        status_d.stable     = (next_grid.flat == cur_grid.flat);  // Fixed point
    end

    // Registering keeps the compare off the output pins
    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            status <= '0;
        end else begin
            status <= status_d;
        end
    end

endmodule

//--- src/life_top.sv
/*
 * 8x8 Life engine. Host loads serially, starts a run, then unloads serially.
 * Keep load_mode and output_mode low while busy. Status lags the grid by a cycle.
 */
`timescale 1ns/100ps

module life_top #(
    parameter int WRAP = 1  // Edge rule for the calculator
) (
    input  logic                       CLK,          // System clock
    input  logic                       RESET,        // Async reset, active high
    input  logic                       load_mode,    // Serial load level
    input  logic                       output_mode,  // Serial unload level
    input  logic                       serial_in,    // Load data, MSB first
    input  logic                       start,        // Run request pulse
    input  logic [life_pkg::GEN_W-1:0] gen_count,    // Generations to run
    output logic                       serial_out,   // Unload data, MSB first
    output logic                       busy,         // Run in progress
    output logic                       done,         // Run finished pulse
    output life_pkg::grid_t            grid_out,     // Current generation
    output life_pkg::status_t          status        // Population and stable flag
);

    life_pkg::grid_t cur_grid;   // Memory contents
    life_pkg::grid_t next_grid;  // One step ahead of cur_grid
    logic            run_mode;   // Memory takes next_grid

    system_memory system_memory_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .grid_in     (next_grid),
        .serial_in   (serial_in),
        .load_mode   (load_mode),
        .run_mode    (run_mode),
        .output_mode (output_mode),
        .grid_out    (cur_grid),
        .serial_out  (serial_out)
    );

    grid_calculator #(
        .WRAP (WRAP)
    ) grid_calculator_inst (
        .grid      (cur_grid),
        .next_grid (next_grid)
    );

    run_sequencer run_sequencer_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .start       (start),
        .load_mode   (load_mode),
        .output_mode (output_mode),
        .gen_count   (gen_count),
        .run_mode    (run_mode),
        .busy        (busy),
        .done        (done)
    );

    population_monitor population_monitor_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .cur_grid  (cur_grid),
        .next_grid (next_grid),
        .status    (status)
    );

    assign grid_out = cur_grid;  // Parallel readout for the host

endmodule

//--- testbench/life_chk.sv
/*
 * Concurrent checks on the run sequencer, bound into every instance.
 * All checks are idle while RESET is high.
 */
`timescale 1ns/100ps

module life_chk (
    input logic CLK,       // Sequencer clock
    input logic RESET,     // Async reset, active high
    input logic run_mode,  // Memory update strobe
    input logic busy,      // Run in progress
    input logic done       // End of run pulse
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (
        @(posedge CLK) disable iff (RESET) done |=> !done
    ) else $error("done stayed high for a second cycle");

    // No generation step outside a run
    run_inside_busy: assert property (
        @(posedge CLK) disable iff (RESET) run_mode |-> busy
    ) else $error("run_mode high while busy is low");

    // Run is over once done fires
    run_off_after_done: assert property (
        @(posedge CLK) disable iff (RESET) done |=> !run_mode
    ) else $error("run_mode high in the cycle after done");

endmodule

bind run_sequencer life_chk life_chk_inst (
    .CLK      (CLK),
    .RESET    (RESET),
    .run_mode (run_mode),
    .busy     (busy),
    .done     (done)
);

//--- testbench/life_tb.sv
/*
 * Testbench for life_top with WRAP=1. Each table entry loads a grid, runs it,
 * then checks grid, status and timing against a software B3/S23 torus model.
 * Random grids come from an xorshift generator with a fixed seed.
 */
`timescale 1ns/100ps

module life_tb;

    localparam int CELLS       = life_pkg::GRID_CELLS;
    localparam int ROWS        = life_pkg::GRID_ROWS;
    localparam int COLS        = life_pkg::GRID_COLS;
    localparam int GEN_W       = life_pkg::GEN_W;
    localparam int DONE_LIMIT  = 300;  // Cycles allowed from start to done
    localparam int IGNORE_WAIT = 20;   // Cycles watched after a rejected start

    // Known patterns, cell (r, c) at bit r*8+c
    localparam logic [CELLS-1:0] BLINKER = 64'h0000_0000_1c00_0000;  // Row 3, cols 2..4
    localparam logic [CELLS-1:0] BLOCK   = 64'h0000_0000_0c0c_0000;  // Rows 2..3, cols 2..3
    localparam logic [CELLS-1:0] GLIDER  = 64'h0000_0000_0007_0402;  // Heads to +r, +c
    localparam logic [CELLS-1:0] CROSS   = 64'h8142_2418_1824_4281;  // Both diagonals

    typedef struct packed {
        logic [CELLS-1:0] pattern;     // Grid to load when use_rand is clear
        logic             use_rand;    // Grid from the xorshift source
        logic [GEN_W-1:0] gens;        // Generations to run
        logic             exp_stable;  // Expected flag, model decides for random grids
    } test_entry_t;

    logic              CLK;
    logic              RESET;
    logic              load_mode;
    logic              output_mode;
    logic              serial_in;
    logic              start;
    logic [GEN_W-1:0]  gen_count;
    logic              serial_out;
    logic              busy;
    logic              done;
    life_pkg::grid_t   grid_out;
    life_pkg::status_t status;

    test_entry_t tests [$];  // Stimulus and expected values
    string       names [$];  // Printable name per entry
    string       cur_name;   // Test in progress, for error lines
    int          errors;
    int          passed;
    int          failed;
    logic [31:0] rng_state;  // xorshift state

    life_top #(
        .WRAP (1)
    ) life_top_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .load_mode   (load_mode),
        .output_mode (output_mode),
        .serial_in   (serial_in),
        .start       (start),
        .gen_count   (gen_count),
        .serial_out  (serial_out),
        .busy        (busy),
        .done        (done),
        .grid_out    (grid_out),
        .status      (status)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;  // 100 ns period
    end

    // 32-bit xorshift, shifts 13, 17, 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One B3/S23 step on a torus
    function automatic logic [CELLS-1:0] life_step(input logic [CELLS-1:0] g);
        logic [CELLS-1:0] n;
        int cnt;
        int rr;
        int cc;
        n = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                cnt = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        rr = (r + dr + ROWS) % ROWS;  // Wrap row
                        cc = (c + dc + COLS) % COLS;  // Wrap column
                        if (dr != 0 || dc != 0) cnt = cnt + int'(g[rr*COLS + cc]);
                    end
                end
                n[r*COLS + c] = (cnt == 3) || (g[r*COLS + c] && cnt == 2);
            end
        end
        return n;
    endfunction

    task automatic add_test(input string name, input logic [CELLS-1:0] pattern,
                            input logic use_rand, input logic [GEN_W-1:0] gens,
                            input logic exp_stable);
        test_entry_t e;
        e.pattern    = pattern;
        e.use_rand   = use_rand;
        e.gens       = gens;
        e.exp_stable = exp_stable;
        tests.push_back(e);
        names.push_back(name);
    endtask

    task automatic check_equal(input string what, input logic [CELLS-1:0] got,
                               input logic [CELLS-1:0] exp);
        assert (got === exp) else begin
            $display("ERR %0d ns: %s: %s is %h, expected %h", $time, cur_name, what, got, exp);
            errors++;
        end
    endtask

    // Shifts a grid in MSB first, optionally with start on the last bit
    task automatic load_grid(input logic [CELLS-1:0] pat, input logic pulse_start);
        load_mode = 1'b1;
        for (int i = CELLS - 1; i >= 0; i--) begin
            serial_in = pat[i];
            start     = pulse_start && (i == 0);  // Must be rejected while loading
            @(negedge CLK);
        end
        load_mode = 1'b0;
        serial_in = 1'b0;
        start     = 1'b0;
    endtask

    task automatic unload_grid(output logic [CELLS-1:0] got);
        got         = '0;
        output_mode = 1'b1;
        for (int k = 0; k < CELLS; k++) begin
            @(negedge CLK);
            got[CELLS-1-k] = serial_out;  // Bit k shows after output edge k+1
        end
        output_mode = 1'b0;
    endtask

    // Start pulse, then count cycles until done
    task automatic run_gens(input logic [GEN_W-1:0] n);
        int cycles;
        gen_count = n;
        start     = 1'b1;
        @(negedge CLK);
        start  = 1'b0;
        cycles = 1;
        check_equal("busy after start", 64'(busy), 64'(1));
        while (!done && cycles < DONE_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!done) begin
            $display("Timeout in %s: no done within %0d cycles of start", cur_name, DONE_LIMIT);
            errors++;
        end else begin
            check_equal("start to done cycles", 64'(cycles), 64'(int'(n) + 1));
        end
    endtask

    task automatic report_test(input int err_before);
        if (errors == err_before) begin
            passed++;
            $display("Test %s: ok", cur_name);
        end else begin
            failed++;
            $display("Test %s: FAILED with %0d errors", cur_name, errors - err_before);
        end
    endtask

    initial begin
        test_entry_t      e;
        logic [CELLS-1:0] pat;
        logic [CELLS-1:0] expected;
        logic [CELLS-1:0] got;
        logic             exp_stable;
        logic             flagged;
        int               err_before;

        RESET       = 1'b1;
        load_mode   = 1'b0;
        output_mode = 1'b0;
        serial_in   = 1'b0;
        start       = 1'b0;
        gen_count   = '0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        rng_state   = 32'hdfa5_c1a2;

        add_test("empty grid",   '0,      1'b0, 8'd1, 1'b1);
        add_test("blinker load", BLINKER, 1'b0, 8'd0, 1'b0);  // Plain load and readback
        add_test("blinker x1",   BLINKER, 1'b0, 8'd1, 1'b0);
        add_test("blinker x2",   BLINKER, 1'b0, 8'd2, 1'b0);  // Back to the start phase
        add_test("block x1",     BLOCK,   1'b0, 8'd1, 1'b1);
        add_test("glider x4",    GLIDER,  1'b0, 8'd4, 1'b0);  // One cell diagonal
        add_test("random x1",    '0,      1'b1, 8'd1, 1'b0);
        add_test("random x4",    '0,      1'b1, 8'd4, 1'b0);

        repeat (3) @(negedge CLK);
        RESET = 1'b0;

        cur_name   = "reset state";
        err_before = errors;
        check_equal("serial_out", 64'(serial_out), '0);
        check_equal("busy", 64'(busy), '0);
        check_equal("done", 64'(done), '0);
        check_equal("status", 64'(status), '0);
        check_equal("grid_out", grid_out.flat, '0);
        report_test(err_before);

        foreach (tests[i]) begin
            e          = tests[i];
            cur_name   = names[i];
            err_before = errors;
            if (e.use_rand) begin
                rng_state  = xorshift32(rng_state);
                pat[63:32] = rng_state;
                rng_state  = xorshift32(rng_state);
                pat[31:0]  = rng_state;
            end else begin
                pat = e.pattern;
            end
            expected = pat;
            repeat (e.gens) expected = life_step(expected);
            exp_stable = e.use_rand ? (life_step(expected) == expected) : e.exp_stable;

            load_grid(pat, 1'b0);
            run_gens(e.gens);
            repeat (2) @(negedge CLK);  // Status lags the grid by one cycle

            check_equal("grid_out", grid_out.flat, expected);
            check_equal("busy after done", 64'(busy), '0);
            check_equal("population", 64'(status.population), 64'($countones(expected)));
            check_equal("stable", 64'(status.stable), 64'(exp_stable));
            unload_grid(got);
            check_equal("serial readback", got, expected);
            report_test(err_before);
        end

        // A start during a load must leave the engine idle
        cur_name   = "start during load";
        err_before = errors;
        gen_count  = GEN_W'(3);
        load_grid(CROSS, 1'b1);
        flagged = 1'b0;
        for (int i = 0; i < IGNORE_WAIT; i++) begin
            if (busy || done) flagged = 1'b1;
            @(negedge CLK);
        end
        assert (!flagged) else begin
            $display("ERR %0d ns: %s: busy or done rose after a rejected start",
                     $time, cur_name);
            errors++;
        end
        check_equal("grid_out", grid_out.flat, CROSS);
        report_test(err_before);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- all.f
src/life_pkg.sv
src/system_memory.sv
src/grid_calculator.sv
src/run_sequencer.sv
src/population_monitor.sv
src/life_top.sv
testbench/life_chk.sv
testbench/life_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Life engine testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module life_tb -f all.f -o life_sim &&
./obj_dir/life_sim | tee /dev/stderr | grep -q "^Testbench passed$" &&
echo "Simulation result: pass" ||
{ echo "Simulation result: fail"; exit 1; }
